// ==== build.f ====
design/rvPkg.sv
design/ctrlIf.sv
design/controlUnit.sv
design/immGen.sv
design/regFile.sv
design/alu.sv
design/pcUnit.sv
design/rvCore.sv
sim/rvCoreTb.sv

// ==== design/alu.sv ====
// Combinational ALU and branch compare; shifts use the low 5 bits of the second operand
`timescale 1ns/100ps
`default_nettype none

module alu (
    ctrlIf.datapath                ctrl,         // aluSrc and aluOp
    input  logic [2:0]             funct3,
    input  logic                   funct7b5,     // instr[30], sub and sra
    input  logic [rvPkg::XLEN-1:0] rs1Data,
    input  logic [rvPkg::XLEN-1:0] rs2Data,
    input  logic [rvPkg::XLEN-1:0] imm,
    output logic [rvPkg::XLEN-1:0] result,
    output logic                   branchTaken
);
    import rvPkg::*;

    logic [XLEN-1:0] opA, opB;
    logic            altOp;                      // sub or sra selected
    logic            ltS, ltU, eq;

    assign opA   = rs1Data;
    assign opB   = ctrl.aluSrc ? imm : rs2Data;
    assign ltS   = $signed(opA) < $signed(opB);
    assign ltU   = opA < opB;
    assign eq    = opA == opB;
    // Immediate forms have no subi so bit 30 only counts for the shifts
    assign altOp = funct7b5 && (ctrl.aluOp == ALU_FUNC || funct3 == F3_SRL_SRA);

    always_comb begin
        result = opA + opB;                      // ALU_ADD and ALU_BRANCH
        if (ctrl.aluOp == ALU_FUNC || ctrl.aluOp == ALU_FUNC_IMM) begin
            case (funct3)
                F3_ADD_SUB: result = altOp ? opA - opB : opA + opB;
                F3_SLL:     result = opA << opB[4:0];
                F3_SLT:     result = {{(XLEN-1){1'b0}}, ltS};
                F3_SLTU:    result = {{(XLEN-1){1'b0}}, ltU};
                F3_XOR:     result = opA ^ opB;
                F3_SRL_SRA: result = altOp ? $unsigned($signed(opA) >>> opB[4:0])
                                           : opA >> opB[4:0];
                F3_OR:      result = opA | opB;
                default:    result = opA & opB;  // F3_AND
            endcase
        end
    end

    always_comb begin
        branchTaken = 1'b0;
        if (ctrl.aluOp == ALU_BRANCH) begin
            case (funct3)
                F3_BEQ:  branchTaken = eq;
                F3_BNE:  branchTaken = !eq;
                F3_BLT:  branchTaken = ltS;
                F3_BGE:  branchTaken = !ltS;
                F3_BLTU: branchTaken = ltU;
                F3_BGEU: branchTaken = !ltU;
                default: branchTaken = 1'b0;     // Reserved funct3 never taken
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/controlUnit.sv ====
// Opcode decoder for the RV32I subset; purely combinational, unknown opcodes force all controls off
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
    input  logic [6:0]    opcode,      // instr[6:0]
    ctrlIf.decoder        ctrl         // Decoded controls
);
    import rvPkg::*;

    always_comb begin
        // Inactive values that each opcode overrides as needed
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.wbSrc    = WB_ALU;
        ctrl.memWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.auiLink  = 1'b0;
        ctrl.aluOp    = ALU_ADD;
        ctrl.error    = 1'b0;
        case (opcode)
            OPC_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSrc    = WB_IMM;         // Immediate goes straight to rd
            end
            OPC_AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.wbSrc    = WB_PC;          // pc plus imm from pcUnit
                ctrl.auiLink  = 1'b1;
            end
            OPC_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.wbSrc    = WB_PC;          // Link is pc plus 4
                ctrl.jump     = 1'b1;
            end
            OPC_JALR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;           // ALU forms rs1 plus imm
                ctrl.wbSrc    = WB_PC;
                ctrl.jump     = 1'b1;
                ctrl.jumpReg  = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = ALU_BRANCH;     // rs1 against rs2
            end
            OPC_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;           // Address is rs1 plus imm
                ctrl.wbSrc    = WB_MEM;
                ctrl.memRead  = 1'b1;
            end
            OPC_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OPC_OPIMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_FUNC_IMM;
            end
            OPC_OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_FUNC;
            end
            default: begin
                ctrl.error    = 1'b1;           // Illegal opcode holds the PC
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/ctrlIf.sv ====
// Decoded control bundle; driven only by the decoder, every datapath block reads it unregistered
`timescale 1ns/100ps
`default_nettype none

interface ctrlIf;
    import rvPkg::*;

    logic  regWrite;                    // Write rd at the edge
    logic  aluSrc;                      // Second ALU operand is the immediate
    wbSrcT wbSrc;                       // Write-back source
    logic  memWrite;                    // Data memory write strobe
    logic  memRead;                     // Data memory read
    logic  jump;                        // jal or jalr
    logic  jumpReg;                     // jalr, target from rs1 plus imm
    logic  branch;                      // Conditional branch
    logic  auiLink;                     // auipc, link value is pc plus imm
    aluOpT aluOp;                       // ALU operation class
    logic  error;                       // Unknown opcode

    modport decoder (output regWrite, aluSrc, wbSrc, memWrite, memRead, jump, jumpReg,
                     branch, auiLink, aluOp, error);
    modport datapath (input regWrite, aluSrc, wbSrc, memWrite, memRead, jump, jumpReg,
                      branch, auiLink, aluOp, error);

endinterface

`default_nettype wire

// ==== design/immGen.sv ====
// Immediate extraction for I, S, B, U and J formats; format chosen from decoded controls, XLEN 32
`timescale 1ns/100ps
`default_nettype none

module immGen (
    input  logic [rvPkg::XLEN-1:0] instr,   // Current instruction word
    ctrlIf.datapath                ctrl,    // Decoded controls
    output logic [rvPkg::XLEN-1:0] imm      // Sign-extended immediate
);
    import rvPkg::*;

    logic [XLEN-1:0] immI, immS, immB, immU, immJ;

    assign immI = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign immS = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};                   // Halfword offset
    assign immU = {instr[31:12], 12'b0};                 // Upper 20 bits
    assign immJ = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                   instr[30:21], 1'b0};

    always_comb begin
        if (ctrl.branch)
            imm = immB;
        else if (ctrl.jump && !ctrl.jumpReg)
            imm = immJ;                                  // jal
        else if (ctrl.wbSrc == WB_IMM || ctrl.auiLink)
            imm = immU;                                  // lui, auipc
        else if (ctrl.memWrite)
            imm = immS;
        else
            imm = immI;                                  // Loads, jalr, ALU immediates
    end

endmodule

`default_nettype wire

// ==== design/pcUnit.sv ====
// PC register and next-PC logic; no misaligned-target trap, illegal opcodes hold the PC
`timescale 1ns/100ps
`default_nettype none

module pcUnit (
    input  logic                   clk,
    input  logic                   arstN,
    ctrlIf.datapath                ctrl,          // Jump, branch and error controls
    input  logic [rvPkg::XLEN-1:0] imm,
    input  logic [rvPkg::XLEN-1:0] aluResult,     // rs1 plus imm for jalr
    input  logic                   branchTaken,
    output logic [rvPkg::XLEN-1:0] pc,
    output logic [rvPkg::XLEN-1:0] linkValue      // Link or auipc result
);
    import rvPkg::*;

    logic [XLEN-1:0] pcPlus4, pcPlusImm, pcNext;

    assign pcPlus4   = pc + XLEN'(4);
    assign pcPlusImm = pc + imm;

    always_comb begin
        if (ctrl.error)
            pcNext = pc;                          // Stall on illegal word
        else if (ctrl.jumpReg)
            pcNext = {aluResult[XLEN-1:1], 1'b0}; // jalr clears bit 0
        else if (ctrl.jump || (ctrl.branch && branchTaken))
            pcNext = pcPlusImm;
        else
            pcNext = pcPlus4;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            pc <= RESET_PC;
        else
            pc <= pcNext;
    end

    assign linkValue = ctrl.auiLink ? pcPlusImm : pcPlus4;

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
// 32x32 register file; two combinational reads, one write at the edge, x0 reads zero
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic                         clk,
    input  logic                         arstN,
    ctrlIf.datapath                      ctrl,        // regWrite and wbSrc
    input  logic [rvPkg::REG_ADDR_W-1:0] rs1Addr,
    input  logic [rvPkg::REG_ADDR_W-1:0] rs2Addr,
    input  logic [rvPkg::REG_ADDR_W-1:0] rdAddr,
    output logic [rvPkg::XLEN-1:0]       rs1Data,
    output logic [rvPkg::XLEN-1:0]       rs2Data,
    input  logic [rvPkg::XLEN-1:0]       aluResult,   // Write-back candidates
    input  logic [rvPkg::XLEN-1:0]       memData,
    input  logic [rvPkg::XLEN-1:0]       imm,
    input  logic [rvPkg::XLEN-1:0]       linkValue
);
    import rvPkg::*;

    logic [XLEN-1:0] regs [1:31];    // x0 not stored
    logic [XLEN-1:0] wbData;

    always_comb begin
        case (ctrl.wbSrc)
            WB_ALU:  wbData = aluResult;
            WB_MEM:  wbData = memData;
            WB_IMM:  wbData = imm;
            default: wbData = linkValue;  // WB_PC
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (ctrl.regWrite && rdAddr != '0) begin
            regs[rdAddr] <= wbData;       // Writes to x0 dropped
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// ==== design/rvCore.sv ====
// Single-cycle RV32I subset core; memories are external and must answer within the same cycle
`timescale 1ns/100ps
`default_nettype none

module rvCore (
    input  logic                   clk,
    input  logic                   arstN,
    output logic [rvPkg::XLEN-1:0] instrAddr,    // Current PC
    input  logic [rvPkg::XLEN-1:0] instrData,    // Combinational fetch
    output logic [rvPkg::XLEN-1:0] dataAddr,
    output logic [rvPkg::XLEN-1:0] dataWdata,
    output logic                   dataWe,       // Sampled at the rising edge
    output logic                   dataRe,
    input  logic [rvPkg::XLEN-1:0] dataRdata,
    output logic                   error         // Illegal opcode presented
);
    import rvPkg::*;

    logic [XLEN-1:0] imm, rs1Data, rs2Data, aluResult, pc, linkValue;
    logic            branchTaken;

    ctrlIf ctrlBus ();

    controlUnit i_controlUnit (.opcode(instrData[6:0]), .ctrl(ctrlBus));

    immGen i_immGen (.instr(instrData), .ctrl(ctrlBus), .imm(imm));

    regFile i_regFile (
        .clk(clk), .arstN(arstN), .ctrl(ctrlBus),
        .rs1Addr(instrData[19:15]), .rs2Addr(instrData[24:20]), .rdAddr(instrData[11:7]),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .aluResult(aluResult), .memData(dataRdata), .imm(imm), .linkValue(linkValue)
    );

    alu i_alu (
        .ctrl(ctrlBus), .funct3(instrData[14:12]), .funct7b5(instrData[30]),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .result(aluResult), .branchTaken(branchTaken)
    );

    pcUnit i_pcUnit (
        .clk(clk), .arstN(arstN), .ctrl(ctrlBus), .imm(imm), .aluResult(aluResult),
        .branchTaken(branchTaken), .pc(pc), .linkValue(linkValue)
    );

    assign instrAddr = pc;
    assign dataAddr  = aluResult;                // rs1 plus imm for lw and sw
    assign dataWdata = rs2Data;
    assign dataWe    = ctrlBus.memWrite;
    assign dataRe    = ctrlBus.memRead;
    assign error     = ctrlBus.error;

endmodule

`default_nettype wire

// ==== design/rvPkg.sv ====
// Shared definitions for the RV32I subset core; XLEN must stay 32, encodings follow the base ISA
`default_nettype none

package rvPkg;

    localparam int XLEN       = 32;                     // Data and address width
    localparam int REG_ADDR_W = 5;                      // Register index width
    localparam logic [XLEN-1:0] RESET_PC = '0;          // PC after reset

    localparam logic [6:0] OPC_LUI    = 7'b0110111;     // lui
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;     // auipc
    localparam logic [6:0] OPC_JAL    = 7'b1101111;     // jal
    localparam logic [6:0] OPC_JALR   = 7'b1100111;     // jalr
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;     // beq .. bgeu
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;     // lw only
    localparam logic [6:0] OPC_STORE  = 7'b0100011;     // sw only
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;     // Register-immediate ALU ops
    localparam logic [6:0] OPC_OP     = 7'b0110011;     // Register-register ALU ops

    // Write-back source select codes
    typedef enum logic [1:0] {
        WB_ALU = 2'b00,                                 // ALU result
        WB_MEM = 2'b01,                                 // Load data
        WB_IMM = 2'b10,                                 // Immediate, lui
        WB_PC  = 2'b11                                  // Link or auipc value
    } wbSrcT;

    typedef enum logic [1:0] {
        ALU_ADD      = 2'b00,                           // Address and auipc-style add
        ALU_BRANCH   = 2'b01,                           // Compare by funct3
        ALU_FUNC     = 2'b10,                           // R-type, funct3 and funct7
        ALU_FUNC_IMM = 2'b11                            // I-type, funct7 for shifts only
    } aluOpT;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;         // add, sub, addi
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;         // funct7 bit 5 picks sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// ==== sim/rvCoreTb.sv ====
// Directed testbench for rvCore; programs load during reset, both memories hold 256 words
`timescale 1ns/100ps
`default_nettype none

module rvCoreTb;
    import rvPkg::*;

    localparam logic [31:0] NOP = 32'h0000_0013;          // addi x0, x0, 0
    localparam int TIMEOUT = 200;                         // Cycles allowed per wait

    logic            clk, arstN, dataWe, dataRe, error;
    logic [XLEN-1:0] instrAddr, instrData, dataAddr, dataWdata, dataRdata;
    logic [31:0]     instrMem [0:255];
    logic [31:0]     dataMem [0:255];
    logic [31:0]     prog [$];                            // Program being built
    logic [31:0]     expQ [$];                            // Expected words or PCs
    integer          seed = 32'h9fae138e;

    rvCore i_rvCore (.clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instrData(instrData),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataRe(dataRe),
        .dataRdata(dataRdata), .error(error));

    assign instrData = (instrAddr[31:10] == '0) ? instrMem[instrAddr[9:2]] : NOP;
    assign dataRdata = dataMem[dataAddr[9:2]];            // Combinational read

    always @(posedge clk) begin
        if (arstN && dataWe)
            dataMem[dataAddr[9:2]] <= dataWdata;          // Ignored during reset
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkVal(input string name, input logic [31:0] expVal, actVal);
        if (actVal !== expVal)
            failRun($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                              name, expVal, actVal));
    endtask

    // Samples at the falling edge and returns at the falling edge of the next instruction
    task automatic waitStore(input string name, output logic [31:0] addr, data);
        int cycles = 0;
        bit seen = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            if (dataWe) begin
                addr = dataAddr;
                data = dataWdata;
                seen = 1'b1;
            end
            @(negedge clk);
            cycles++;
        end
        if (!seen)
            failRun($sformatf("No store was seen before the timeout in test %s", name));
    endtask

    task automatic loadAndReset();
        @(negedge clk);
        arstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = (i < prog.size()) ? prog[i] : NOP;
            dataMem[i]  = 32'hda7a_0000 | i;              // Tagged by word index
        end
        repeat (2) @(negedge clk);
        arstN = 1'b1;                                     // PC 0 presented from here
    endtask

    function automatic logic [31:0] rType(input logic alt, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // sw
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // RV32I result of an OP or OP-IMM instruction with b already sign-extended
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: if (alt) return sa >>> b[4:0];
                        else return a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic bit branchModel(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;                       // bgeu
        endcase
    endfunction

    task automatic aluOpsTest();
        logic [11:0] immA, immB, immOp;
        logic [31:0] a, b, addr, data;
        logic [2:0]  f3;
        logic        alt;
        immA = 12'($random(seed));
        immB = 12'($random(seed));
        a = {{20{immA[11]}}, immA};
        b = {{20{immB[11]}}, immB};
        prog.delete();
        expQ.delete();
        prog.push_back(iType(OPC_OPIMM, F3_ADD_SUB, 5'd1, 5'd0, immA));
        prog.push_back(iType(OPC_OPIMM, F3_ADD_SUB, 5'd2, 5'd0, immB));
        for (int k = 0; k < 20; k++) begin                // 0..9 R-type, 10..19 I-type
            if (k == 18)
                continue;                                 // No subi
            f3  = (k % 10 < 8) ? 3'(k % 10) : ((k % 10 == 8) ? F3_ADD_SUB : F3_SRL_SRA);
            alt = (k % 10 >= 8);                          // sub and sra
            if (k < 10) begin
                prog.push_back(rType(alt, f3, 5'd3, 5'd1, 5'd2));
                expQ.push_back(aluModel(f3, alt, a, b));
            end else begin
                immOp = (f3 == F3_SLL || f3 == F3_SRL_SRA) ? {1'b0, alt, 5'b0, immB[4:0]} : immB;
                prog.push_back(iType(OPC_OPIMM, f3, 5'd3, 5'd1, immOp));
                expQ.push_back(aluModel(f3, alt, a, {{20{immOp[11]}}, immOp}));
            end
            prog.push_back(sType(5'd3, 5'd0, 12'(4 * expQ.size())));
        end
        loadAndReset();
        foreach (expQ[i]) begin
            waitStore("alu", addr, data);
            checkVal($sformatf("alu op %0d f3=%0d", i, prog[2 * i + 2][14:12]), expQ[i], data);
        end
    endtask

    task automatic memoryTest();
        logic [31:0] val, expVal, addr, data;
        val = $random(seed);
        expVal = {val[31:12], 12'b0} + {{20{val[11]}}, val[11:0]};  // lui then addi
        prog.delete();
        prog.push_back({val[31:12], 5'd1, OPC_LUI});
        prog.push_back(iType(OPC_OPIMM, F3_ADD_SUB, 5'd1, 5'd1, val[11:0]));
        prog.push_back(sType(5'd1, 5'd0, 12'h040));       // Address A
        prog.push_back(iType(OPC_LOAD, 3'b010, 5'd4, 5'd0, 12'h040));
        prog.push_back(sType(5'd4, 5'd0, 12'h080));       // Address B
        loadAndReset();
        waitStore("mem sw A", addr, data);
        checkVal("mem sw A addr", 32'h40, addr);
        checkVal("mem lw dataRe", 32'd1, dataRe);         // lw presented now
        waitStore("mem sw B", addr, data);
        checkVal("mem sw B addr", 32'h80, addr);
        checkVal("mem sw B data", expVal, data);
    endtask

    task automatic upperImmTest();
        logic [19:0] hiA, hiB;
        logic [31:0] addr, data;
        hiA = 20'($random(seed));
        hiB = 20'($random(seed));
        prog.delete();
        prog.push_back({hiA, 5'd5, OPC_LUI});
        prog.push_back(sType(5'd5, 5'd0, 12'd0));
        prog.push_back(NOP);
        prog.push_back({hiB, 5'd6, OPC_AUIPC});          // At address 12
        prog.push_back(sType(5'd6, 5'd0, 12'd4));
        loadAndReset();
        waitStore("lui", addr, data);
        checkVal("lui", {hiA, 12'b0}, data);
        waitStore("auipc", addr, data);
        checkVal("auipc", 32'd12 + {hiB, 12'b0}, data);
    endtask

    task automatic branchTest();
        logic [31:0] regVal [1:2];
        logic [4:0]  rs1, rs2;
        logic [2:0]  f3;
        int          pc;
        regVal[1] = 32'hffff_fffb;                        // -5
        regVal[2] = 32'd3;
        prog.delete();
        expQ.delete();
        prog.push_back(iType(OPC_OPIMM, F3_ADD_SUB, 5'd1, 5'd0, 12'hffb));
        prog.push_back(iType(OPC_OPIMM, F3_ADD_SUB, 5'd2, 5'd0, 12'd3));
        expQ.push_back(32'd0);
        expQ.push_back(32'd4);
        for (int k = 0; k < 18; k++) begin                // Pairs x1,x2 then x2,x1 then x1,x1
            f3  = (k / 3 < 2) ? 3'(k / 3) : 3'(k / 3 + 2);
            rs1 = (k % 3 == 1) ? 5'd2 : 5'd1;
            rs2 = (k % 3 == 0) ? 5'd2 : 5'd1;
            pc  = prog.size() * 4;
            prog.push_back(bType(f3, rs1, rs2, 13'd12));
            prog.push_back(NOP);
            prog.push_back(NOP);
            expQ.push_back(pc);
            if (!branchModel(f3, regVal[rs1], regVal[rs2])) begin
                expQ.push_back(pc + 4);                   // Falls through the nops
                expQ.push_back(pc + 8);
            end
        end
        expQ.push_back(prog.size() * 4);
        loadAndReset();
        foreach (expQ[i]) begin
            checkVal($sformatf("branch step %0d", i), expQ[i], instrAddr);
            @(negedge clk);
        end
    endtask

    task automatic jumpTest();
        logic [31:0] addr, data;
        prog.delete();
        prog.push_back(jType(5'd1, 21'd16));              // jal x1, +16
        repeat (3) prog.push_back(NOP);
        prog.push_back(sType(5'd1, 5'd0, 12'd0));
        prog.push_back(iType(OPC_OPIMM, F3_ADD_SUB, 5'd2, 5'd0, 12'd41));
        prog.push_back(iType(OPC_JALR, 3'b000, 5'd3, 5'd2, 12'd0));  // At address 24
        repeat (3) prog.push_back(NOP);
        prog.push_back(sType(5'd3, 5'd0, 12'd4));         // At address 40
        loadAndReset();
        checkVal("jal pc", 32'd0, instrAddr);
        @(negedge clk);
        checkVal("jal target", 32'd16, instrAddr);
        waitStore("jal link", addr, data);
        checkVal("jal link", 32'd0 + 32'd4, data);
        @(negedge clk);
        checkVal("jalr pc", 32'd24, instrAddr);
        @(negedge clk);
        checkVal("jalr target", 32'd41 & ~32'd1, instrAddr);
        waitStore("jalr link", addr, data);
        checkVal("jalr link", 32'd24 + 32'd4, data);
    endtask

    task automatic zeroRegTest();
        logic [31:0] addr, data;
        prog.delete();
        prog.push_back(iType(OPC_OPIMM, F3_ADD_SUB, 5'd0, 5'd0, 12'd123));
        prog.push_back(sType(5'd0, 5'd0, 12'd8));
        loadAndReset();
        waitStore("x0", addr, data);
        checkVal("x0 stays zero", 32'd0, data);
    endtask

    task automatic illegalOpTest();
        prog.delete();
        prog.push_back(iType(OPC_OPIMM, F3_ADD_SUB, 5'd1, 5'd0, 12'd5));
        prog.push_back(32'h0000_0000);                    // Illegal word at address 4
        prog.push_back(sType(5'd1, 5'd0, 12'd0));
        loadAndReset();
        @(negedge clk);
        repeat (5) begin
            checkVal("illegal error", 32'd1, error);
            checkVal("illegal pc hold", 32'd4, instrAddr);
            checkVal("illegal no store", 32'd0, dataWe);
            @(negedge clk);
        end
    endtask

    initial begin
        arstN = 1'b0;
        aluOpsTest();
        memoryTest();
        upperImmTest();
        branchTest();
        jumpTest();
        zeroRegTest();
        illegalOpTest();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
